/* rtl/execPkg.sv */
`default_nettype none

package execPkg;

	// Operation codes seen by the execute stage
	typedef enum logic [4:0] {
		ADD,
		SUB,
		MUL,
		MULH,
		MULHU,
		MULHSU,
		DIV,
		DIVU,
		REM,
		REMU,
		XOR,
		AND,
		OR,
		NOT,
		SLL,
		SRL,
		SRA,
		LESS,
		LESSU,
		EQUAL,
		NEQ,
		GTE,
		GTEU,
		IMMVAL,
		JUMPUNCOND
	} opcodeE;

	typedef enum logic [1:0] {
		RTYPE,
		ITYPE,
		STYPE,
		UTYPE
	} instrTypeE;

	// Request after the second operand is resolved
	typedef struct packed {
		opcodeE      opcode;
		logic [63:0] opA;
		logic [63:0] opB;
		logic [7:0]  tag;
	} aluReqT;

	typedef struct packed {
		logic [63:0] result;
		logic [7:0]  tag;
	} aluRespT;

	// Ops that go to the iterative divider
	function automatic logic isDivOp(input opcodeE op);
		return op inside {DIV, DIVU, REM, REMU};
	endfunction

endpackage

`default_nettype wire

/* rtl/aluCore.sv */
`timescale 1ns/1ps
`default_nettype none

module aluCore (
	input  execPkg::opcodeE opcode,
	input  wire             logic [63:0] opA,
	input  wire             logic [63:0] opB,
	output logic            [63:0] result
);
	import execPkg::*;

	logic [127:0] prodSS;
	logic [127:0] prodUU;
	logic [127:0] prodSU;
	logic [5:0]   shAmt;

	// Operands widened to 128 bits so the low half of each product is exact
	assign prodSS = $signed({{64{opA[63]}}, opA}) * $signed({{64{opB[63]}}, opB});
	assign prodUU = {64'b0, opA} * {64'b0, opB};
	assign prodSU = $signed({{64{opA[63]}}, opA}) * $signed({64'b0, opB});

	assign shAmt = opB[5:0];

	always_comb begin
		case (opcode)
			ADD:    result = opA + opB;
			SUB:    result = opA - opB;
			MUL:    result = prodSS[63:0];
			MULH:   result = prodSS[127:64];
			MULHU:  result = prodUU[127:64];
			MULHSU: result = prodSU[127:64]; // rs1 signed, rs2 unsigned
			XOR:    result = opA ^ opB;
			AND:    result = opA & opB;
			OR:     result = opA | opB;
			NOT:    result = ~opA;
			SLL:    result = opA << shAmt;
			SRL:    result = opA >> shAmt;
			SRA:    result = $signed(opA) >>> shAmt; // Sign fill
			LESS: begin
				result = {63'b0, $signed(opA) < $signed(opB)};
			end
			LESSU: begin
				// Also covers sltiu, the immediate is already sign extended
				result = {63'b0, opA < opB};
			end
			EQUAL: begin
				result = {63'b0, opA == opB};
			end
			NEQ: begin
				result = {63'b0, opA != opB};
			end
			GTE: begin
				result = {63'b0, $signed(opA) >= $signed(opB)};
			end
			GTEU: begin
				result = {63'b0, opA >= opB};
			end
			IMMVAL:     result = opB;
			JUMPUNCOND: result = opB;
			default:    result = '0; // Divide ops are handled elsewhere
		endcase
	end

endmodule

`default_nettype wire

/* rtl/serialDivider.sv */
`timescale 1ns/1ps
`default_nettype none

module serialDivider (
	input  wire             logic clk,
	input  wire             logic rstN,
	input  wire             logic start,
	input  execPkg::opcodeE opcode,
	input  wire             logic [63:0] dividend,
	input  wire             logic [63:0] divisor,
	output logic            done,
	output logic            [63:0] result
);
	import execPkg::*;

	logic        busy;
	logic [6:0]  count;
	logic [63:0] rem;
	logic [63:0] quo;
	logic [63:0] dvs;
	logic        isRem;
	logic        negQ;
	logic        negR;
	logic        divZero;
	logic        signedOp;
	logic [63:0] magA;
	logic [63:0] magB;
	logic [63:0] quoFix;
	logic [63:0] remFix;

	// One restoring step, returns {remainder, quotient}
	function automatic logic [127:0] divStep(input logic [63:0] r, input logic [63:0] q,
			input logic [63:0] d);
		logic [64:0] shifted;
		logic [64:0] diff;
		shifted = {r, q[63]};
		diff    = shifted - {1'b0, d};
		if (!diff[64]) return {diff[63:0], q[62:0], 1'b1};
		return {shifted[63:0], q[62:0], 1'b0};
	endfunction

	assign signedOp = opcode inside {DIV, REM};
	assign magA = (signedOp && dividend[63]) ? -dividend : dividend;
	assign magB = (signedOp && divisor[63]) ? -divisor : divisor;

	assign done = busy && (count == 7'd64);

	// Most negative by minus one falls out of the magnitude path unchanged
	assign quoFix = divZero ? '1 : (negQ ? -quo : quo);
	assign remFix = negR ? -rem : rem; // Zero divisor leaves the dividend here
	assign result = isRem ? remFix : quoFix;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy  <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy  <= 1'b1;
			count <= 7'd1; // First step runs on the start edge
		end else if (done) begin
			busy <= 1'b0;
		end else if (busy) begin
			count <= count + 7'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			{rem, quo} <= divStep(64'b0, magA, magB);
			dvs        <= magB;
			isRem      <= opcode inside {REM, REMU};
			negQ       <= signedOp && (dividend[63] ^ divisor[63]);
			negR       <= signedOp && dividend[63];
			divZero    <= (divisor == '0);
		end else if (busy && !done) begin
			{rem, quo} <= divStep(rem, quo, dvs);
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) start |-> !busy);

endmodule

`default_nettype wire

/* rtl/operandSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module operandSelect (
	input  wire                logic clk,
	input  wire                logic rstN,
	input  wire                logic inStrobe,
	input  execPkg::opcodeE    opcode,
	input  execPkg::instrTypeE instrType,
	input  wire                logic [63:0] value1,
	input  wire                logic [63:0] value2,
	input  wire                logic [31:0] immediate,
	input  wire                logic [5:0] shamt,
	input  wire                logic [7:0] tag,
	output logic               reqStrobe,
	output execPkg::aluReqT    req
);
	import execPkg::*;

	logic [63:0] immExt;
	logic [63:0] opB;
	logic        isShift;

	assign immExt  = {{32{immediate[31]}}, immediate};
	assign isShift = opcode inside {SLL, SRL, SRA};

	always_comb begin
		if (opcode inside {IMMVAL, JUMPUNCOND}) begin
			opB = immExt; // lui, auipc and jumps carry the immediate
		end else begin
			case (instrType)
				RTYPE:        opB = value2;
				ITYPE:        opB = isShift ? {58'b0, shamt} : immExt;
				STYPE, UTYPE: opB = immExt;
				default:      opB = immExt;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			reqStrobe <= 1'b0;
		end else begin
			reqStrobe <= inStrobe;
		end
	end

	always_ff @(posedge clk) begin
		if (inStrobe) begin
			req.opcode <= opcode;
			req.opA    <= value1;
			req.opB    <= opB;
			req.tag    <= tag;
		end
	end

endmodule

`default_nettype wire

/* rtl/execQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module execQueue #(
	parameter int queueDepth = 4
) (
	input  wire             logic clk,
	input  wire             logic rstN,
	input  wire             logic reqStrobe,
	input  execPkg::aluReqT req,
	input  wire             logic pop,
	output execPkg::aluReqT head,
	output logic            notEmpty,
	output logic            overrun
);
	import execPkg::*;

	localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int cntW = $clog2(queueDepth + 1);

	aluReqT            mem [queueDepth];
	logic [ptrW-1:0]   rdPtr;
	logic [ptrW-1:0]   wrPtr;
	logic [cntW-1:0]   count;
	logic              full;
	logic              pushOk;

	assign full     = (count == cntW'(queueDepth));
	assign pushOk   = reqStrobe && !full; // Full queue drops the request
	assign notEmpty = (count != '0);
	assign head     = mem[rdPtr];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdPtr   <= '0;
			wrPtr   <= '0;
			count   <= '0;
			overrun <= 1'b0;
		end else begin
			if (pushOk) begin
				wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			count <= count + cntW'(pushOk) - cntW'(pop);
			if (reqStrobe && full) overrun <= 1'b1; // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (pushOk) mem[wrPtr] <= req;
	end

	// Consumer only pops what is there
	assert property (@(posedge clk) disable iff (!rstN) pop |-> notEmpty);
	assert property (@(posedge clk) disable iff (!rstN) count <= cntW'(queueDepth));

endmodule

`default_nettype wire

/* rtl/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
	input  wire              logic clk,
	input  wire              logic rstN,
	input  execPkg::aluReqT  head,
	input  wire              logic notEmpty,
	output logic             pop,
	output logic             resultStrobe,
	output execPkg::aluRespT resp
);
	import execPkg::*;

	typedef enum logic {IDLE, BUSY} stateE;

	stateE       state;
	logic        startDiv;
	logic        divDone;
	logic [63:0] aluResult;
	logic [63:0] divResult;
	logic [7:0]  tagQ;

	assign pop      = (state == IDLE) && notEmpty;
	assign startDiv = pop && isDivOp(head.opcode);

	aluCore aluCore_i (
		.opcode (head.opcode),
		.opA    (head.opA),
		.opB    (head.opB),
		.result (aluResult)
	);

	serialDivider serialDivider_i (
		.clk      (clk),
		.rstN     (rstN),
		.start    (startDiv),
		.opcode   (head.opcode),
		.dividend (head.opA),
		.divisor  (head.opB),
		.done     (divDone),
		.result   (divResult)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state        <= IDLE;
			resultStrobe <= 1'b0;
		end else begin
			resultStrobe <= (pop && !startDiv) || divDone;
			if (startDiv) state <= BUSY; // Hold the queue until the quotient is back
			else if (divDone) state <= IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) tagQ <= head.tag;
		if (pop && !startDiv) begin
			resp <= '{result: aluResult, tag: head.tag};
		end else if (divDone) begin
			resp <= '{result: divResult, tag: tagQ};
		end
	end

endmodule

`default_nettype wire

/* rtl/execTop.sv */
`timescale 1ns/1ps
`default_nettype none

module execTop #(
	parameter int queueDepth = 4
) (
	input  wire                logic clk,
	input  wire                logic rstN,
	input  wire                logic inStrobe,
	input  execPkg::opcodeE    opcode,
	input  execPkg::instrTypeE instrType,
	input  wire                logic [63:0] value1,
	input  wire                logic [63:0] value2,
	input  wire                logic [31:0] immediate,
	input  wire                logic [5:0] shamt,
	input  wire                logic [7:0] tag,
	output logic               resultStrobe,
	output execPkg::aluRespT   resp,
	output logic               overrun
);
	import execPkg::*;

	logic   reqStrobe;
	aluReqT req;
	aluReqT head;
	logic   notEmpty;
	logic   pop;

	operandSelect operandSelect_i (
		.clk       (clk),
		.rstN      (rstN),
		.inStrobe  (inStrobe),
		.opcode    (opcode),
		.instrType (instrType),
		.value1    (value1),
		.value2    (value2),
		.immediate (immediate),
		.shamt     (shamt),
		.tag       (tag),
		.reqStrobe (reqStrobe),
		.req       (req)
	);

	execQueue #(
		.queueDepth (queueDepth)
	) execQueue_i (
		.clk       (clk),
		.rstN      (rstN),
		.reqStrobe (reqStrobe),
		.req       (req),
		.pop       (pop),
		.head      (head),
		.notEmpty  (notEmpty),
		.overrun   (overrun)
	);

	execUnit execUnit_i (
		.clk          (clk),
		.rstN         (rstN),
		.head         (head),
		.notEmpty     (notEmpty),
		.pop          (pop),
		.resultStrobe (resultStrobe),
		.resp         (resp)
	);

endmodule

`default_nettype wire

/* sim/execTb.sv */
`timescale 1ns/1ps
`default_nettype none

module execTb;
	import execPkg::*;

	localparam int queueDepth = 4;
	localparam int clkPeriod  = 100;
	localparam int testCount  = 118; // Strobes issued over all behaviors
	localparam logic [63:0] minVal = 64'h8000_0000_0000_0000;

	logic        clk = 1'b0;
	logic        rstN;
	logic        inStrobe;
	opcodeE      opcode;
	instrTypeE   instrType;
	logic [63:0] value1;
	logic [63:0] value2;
	logic [31:0] immediate;
	logic [5:0]  shamt;
	logic [7:0]  tag;
	logic        resultStrobe;
	aluRespT     resp;
	logic        overrun;

	aluRespT     expQ[$];  // Expected responses in issue order
	aluRespT     expFront;
	int          pending     = 0;
	int          outstanding = 0;
	int          resultCount = 0;
	int          valueErrors = 0;
	int          otherErrors = 0;
	logic [7:0]  nextTag     = 8'd0;

	opcodeE logicOps [14] = '{ADD, SUB, XOR, AND, OR, NOT, LESS, LESSU, EQUAL, NEQ, GTE, GTEU,
		IMMVAL, JUMPUNCOND};
	opcodeE shiftOps [3] = '{SLL, SRL, SRA};
	opcodeE mulOps [4]   = '{MUL, MULH, MULHU, MULHSU};
	opcodeE divOps [4]   = '{DIV, DIVU, REM, REMU};
	logic [63:0] divA [6] = '{64'd7, -64'd7, 64'd7, -64'd7, 64'd123, minVal};
	logic [63:0] divB [6] = '{64'd2, 64'd2, -64'd2, -64'd2, 64'd0, '1};

	execTop #(.queueDepth(queueDepth)) execTop_i (
		.clk (clk), .rstN (rstN), .inStrobe (inStrobe), .opcode (opcode),
		.instrType (instrType), .value1 (value1), .value2 (value2), .immediate (immediate),
		.shamt (shamt), .tag (tag), .resultStrobe (resultStrobe), .resp (resp),
		.overrun (overrun)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [63:0] signExtImm(input logic [31:0] imm);
		return {{32{imm[31]}}, imm};
	endfunction

	// Second operand as the decoder rules define it
	function automatic logic [63:0] resolveOpB(input opcodeE op, input instrTypeE it,
			input logic [63:0] v2, input logic [31:0] imm, input logic [5:0] sh);
		if (op == IMMVAL || op == JUMPUNCOND) return signExtImm(imm);
		if (it == RTYPE) return v2;
		if (it == ITYPE && (op == SLL || op == SRL || op == SRA)) return {58'b0, sh};
		return signExtImm(imm);
	endfunction

	function automatic logic [63:0] mulHighU(input logic [63:0] a, input logic [63:0] b);
		logic [127:0] p;
		p = {64'b0, a} * {64'b0, b};
		return p[127:64];
	endfunction

	function automatic logic [63:0] divideModel(input opcodeE op, input logic [63:0] a,
			input logic [63:0] b);
		logic sgn;
		logic wantRem;
		sgn     = (op == DIV || op == REM);
		wantRem = (op == REM || op == REMU);
		if (b == 64'b0) return wantRem ? a : '1; // RISC-V divide by zero
		if (sgn && a == minVal && b == '1) return wantRem ? 64'b0 : a;
		if (sgn) return wantRem ? ($signed(a) % $signed(b)) : ($signed(a) / $signed(b));
		return wantRem ? a % b : a / b;
	endfunction

	function automatic logic [63:0] expectedResult(input opcodeE op, input logic [63:0] a,
			input logic [63:0] b);
		logic [5:0]  s;
		logic [63:0] fill;
		s    = b[5:0];
		fill = a[63] ? ~({64{1'b1}} >> s) : 64'b0; // Sign bits that SRA shifts in
		case (op)
			ADD:    return a + b;
			SUB:    return a - b;
			MUL:    return a * b;
			// High halves from the unsigned product with signed corrections
			MULH:   return mulHighU(a, b) - (a[63] ? b : 64'b0) - (b[63] ? a : 64'b0);
			MULHU:  return mulHighU(a, b);
			MULHSU: return mulHighU(a, b) - (a[63] ? b : 64'b0);
			DIV, DIVU, REM, REMU: return divideModel(op, a, b);
			XOR:    return a ^ b;
			AND:    return a & b;
			OR:     return a | b;
			NOT:    return ~a;
			SLL:    return a << s;
			SRL:    return a >> s;
			SRA:    return (a >> s) | fill;
			LESS:   return {63'b0, $signed(a) < $signed(b)};
			LESSU:  return {63'b0, a < b};
			EQUAL:  return {63'b0, a == b};
			NEQ:    return {63'b0, a != b};
			GTE:    return {63'b0, !($signed(a) < $signed(b))};
			GTEU:   return {63'b0, !(a < b)};
			default: return b; // Immediate passes
		endcase
	endfunction

	function automatic logic [63:0] randOperand();
		case ($urandom_range(5))
			0: return 64'b0;
			1: return '1;
			2: return minVal;
			default: return {$urandom, $urandom};
		endcase
	endfunction

	// Drives one strobe on the current falling edge and returns on the next one
	task automatic issueOp(input opcodeE op, input instrTypeE it, input logic [63:0] v1,
			input logic [63:0] v2, input logic [31:0] imm, input logic [5:0] sh,
			input bit accepted);
		aluRespT expResp;
		inStrobe  = 1'b1;
		opcode    = op;
		instrType = it;
		value1    = v1;
		value2    = v2;
		immediate = imm;
		shamt     = sh;
		tag       = nextTag;
		if (accepted) begin
			expResp.result = expectedResult(op, v1, resolveOpB(op, it, v2, imm, sh));
			expResp.tag    = nextTag;
			expQ.push_back(expResp);
			outstanding++;
		end
		nextTag++;
		@(negedge clk);
		inStrobe = 1'b0;
	endtask

	task automatic drainResults();
		while (outstanding != 0) @(negedge clk);
	endtask

	task automatic runOne(input opcodeE op, input instrTypeE it, input logic [63:0] v1,
			input logic [63:0] v2);
		issueOp(op, it, v1, v2, $urandom, 6'($urandom), 1'b1);
		drainResults();
	endtask

	always @(posedge clk) begin
		if (rstN && resultStrobe && expQ.size() != 0) begin
			expQ.delete(0); // Retired after the check at this edge
			outstanding--;
			resultCount++;
		end
	end

	always @(negedge clk) begin
		pending  = expQ.size();
		expFront = (expQ.size() != 0) ? expQ[0] : '0;
	end

	respCheck: assert property (@(posedge clk) disable iff (!rstN)
			resultStrobe |-> resp == expFront)
		else begin
			valueErrors++;
			$display("ERROR resp got %h expected %h", $sampled(resp), $sampled(expFront));
		end

	extraCheck: assert property (@(posedge clk) disable iff (!rstN)
			resultStrobe |-> pending != 0)
		else begin
			otherErrors++;
			$display("A result arrived with no instruction outstanding");
		end

	initial begin
		#(testCount * 70 * clkPeriod + 50 * clkPeriod);
		$display("Timeout with %0d results outstanding", outstanding);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h3a0e_26ba));
		rstN      = 1'b0;
		inStrobe  = 1'b0;
		opcode    = ADD;
		instrType = RTYPE;
		value1    = '0;
		value2    = '0;
		immediate = '0;
		shamt     = '0;
		tag       = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		for (int i = 0; i < 40; i++) begin
			runOne(logicOps[$urandom_range(13)], instrTypeE'($urandom_range(3)),
				randOperand(), randOperand());
		end
		// Even rounds take shamt and odd rounds value2, with value1 mostly negative
		for (int i = 0; i < 6; i++) begin
			foreach (shiftOps[k]) begin
				runOne(shiftOps[k], (i % 2 == 0) ? ITYPE : RTYPE,
					{i % 3 != 0, 63'({$urandom, $urandom})}, {$urandom, $urandom});
			end
		end
		for (int i = 0; i < 5; i++) begin
			foreach (mulOps[k]) runOne(mulOps[k], RTYPE, randOperand(), randOperand());
		end
		foreach (divOps[k]) begin
			foreach (divA[j]) runOne(divOps[k], RTYPE, divA[j], divB[j]);
			runOne(divOps[k], RTYPE, randOperand(), randOperand());
		end

		// Burst queued behind a divide fills the queue exactly
		issueOp(DIV, RTYPE, {$urandom, $urandom}, 64'd13, '0, '0, 1'b1);
		for (int i = 0; i < queueDepth; i++) begin
			issueOp(logicOps[$urandom_range(13)], RTYPE, randOperand(), randOperand(),
				$urandom, '0, 1'b1);
		end
		drainResults();
		burstNoOverrun: assert (!overrun) else begin
			otherErrors++;
			$display("Overrun set by a burst that fits in the queue");
		end

		// Overfill while the divider holds the queue so the last two strobes are dropped
		issueOp(DIVU, RTYPE, randOperand(), 64'd3, '0, '0, 1'b1);
		repeat (2) @(negedge clk);
		for (int i = 0; i < queueDepth + 2; i++) begin
			issueOp(ADD, RTYPE, randOperand(), randOperand(), '0, '0, i < queueDepth);
		end
		@(negedge clk);
		overrunSet: assert (overrun) else begin
			otherErrors++;
			$display("Overrun stayed low after the queue was overfilled");
		end
		drainResults();
		@(negedge clk);
		rstN = 1'b0;
		repeat (3) @(negedge clk);
		resetClear: assert (!overrun && !resultStrobe) else begin
			otherErrors++;
			$display("Reset did not clear overrun and the result strobe");
		end
		rstN = 1'b1;
		repeat (2) @(negedge clk);

		$display("Results %0d, value errors %0d, other errors %0d",
			resultCount, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
rtl/execPkg.sv
rtl/aluCore.sv
rtl/serialDivider.sv
rtl/operandSelect.sv
rtl/execQueue.sv
rtl/execUnit.sv
rtl/execTop.sv
sim/execTb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module execTb
./obj_dir/VexecTb | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation passed"
